// ==== src.f ====
coupe_pkg.sv
io_bus_if.sv
paging_if.sv
port_regs.sv
mem_mapper.sv
midi_serial.sv
vox_dac.sv
audio_mixer.sv
coupe_asic.sv
tb_coupe_asic.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_coupe_asic
LINT_TOP  ?= coupe_asic
FILELIST  ?= src.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing --timescale 1ns/1ps \
		--top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_coupe_asic.sv ====
// SAM Coupe ASIC testbench
`default_nettype none

module tb_coupe_asic;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CE_DIV = 8;
	localparam int FRAME  = coupe_pkg::MIDI_FRAME_TICKS * CE_DIV; // MIDI window in cycles
	localparam int INT_CY = coupe_pkg::MIDI_INT_TICKS * CE_DIV;

	// Rough length of the tests in cycles
	localparam int TEST_CYCLES = 200 * 16 + 10 * 100 + 50 * 8 + 100 * 8
		+ 6 * FRAME + 200 * CE_DIV;
	localparam int LIMIT = 2 * TEST_CYCLES;

	logic                 clk_sys;
	logic                 reset;
	coupe_pkg::cpu_addr_t addr;
	coupe_pkg::byte_t     din;
	logic                 io_wr;
	logic                 ext_ram_off;
	coupe_pkg::sample_t   sid_sample;
	logic                 sid_active;
	coupe_pkg::byte_t     asic_dout;
	coupe_pkg::mem_addr_t mem_addr;
	logic                 mem_rom;
	logic                 mem_write_ok;
	logic [3:0]           border_color;
	logic                 midi_tx;
	logic                 midi_int;
	coupe_pkg::sample_t   audio_l;
	coupe_pkg::sample_t   audio_r;

	integer seed   = 28532;
	int     cycles = 0;
	int     checks = 0;
	int     errors = 0;
	int     tests  = 0;
	int     errors_at_start;
	string  test_name;

	// ====================
	// Reference model state
	// ====================
	logic [7:0] lmpr_m;
	logic [7:0] hmpr_m;
	logic [7:0] ext_c_m;
	logic [7:0] ext_d_m;
	logic [7:0] border_m;
	logic [7:0] lpt_m;   // Last LPT data byte
	logic [7:0] vox_l_m;
	logic [7:0] vox_r_m;
	logic       ext_ena_m;
	logic       stb_m;

	coupe_asic #(.CE_DIV(CE_DIV)) dut_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run went past %0d cycles", LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Mismatch in %s, %s: expected %0h, actual %0h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("Test %s finished with %0d errors", test_name, errors - errors_at_start);
	endtask

	task automatic apply_reset(input logic ram_off);
		@(posedge clk_sys);
		reset       <= 1'b1;
		ext_ram_off <= ram_off; // Held until the next reset
		repeat (3) @(posedge clk_sys);
		reset     <= 1'b0;
		lmpr_m    = '0;
		hmpr_m    = '0;
		ext_c_m   = '0;
		ext_d_m   = '0;
		border_m  = '0;
		vox_l_m   = '0;
		vox_r_m   = '0;
		stb_m     = 1'b0;
		ext_ena_m = !ram_off;
	endtask

	// Two cycles of io_wr high, two low, then the model follows
	task automatic write_port(input logic [7:0] port, input logic [7:0] data);
		@(posedge clk_sys);
		addr  <= {8'($random(seed)), port};
		din   <= data;
		io_wr <= 1'b1;
		repeat (2) @(posedge clk_sys);
		io_wr <= 1'b0;
		repeat (2) @(posedge clk_sys);
		case (port)
			coupe_pkg::PORT_LMPR:     lmpr_m   = data;
			coupe_pkg::PORT_HMPR:     hmpr_m   = data;
			coupe_pkg::PORT_EXT_C:    ext_c_m  = data;
			coupe_pkg::PORT_EXT_D:    ext_d_m  = data;
			coupe_pkg::PORT_BORDER:   border_m = data;
			coupe_pkg::PORT_LPT_DATA: lpt_m    = data;
			coupe_pkg::PORT_LPT_STB: begin
				if (!stb_m && data[0])
					vox_l_m = lpt_m;
				if (stb_m && !data[0])
					vox_r_m = lpt_m;
				stb_m = data[0];
			end
			default: ;
		endcase
	endtask

	task automatic set_addr(input logic [15:0] a);
		@(posedge clk_sys);
		addr <= a;
		@(negedge clk_sys); // Outputs settled
	endtask

	// Returns {rom, write_ok, physical address}
	function automatic logic [24:0] map_ref(input logic [15:0] a);
		logic [1:0] sect;
		logic       rom;
		logic       ext;
		logic       wok;
		logic [4:0] pg5;
		logic [8:0] page;
		sect = a[15:14];
		rom  = (sect == 2'd0 && !lmpr_m[5]) || (sect == 2'd3 && lmpr_m[6]);
		ext  = hmpr_m[7] && a[15];
		pg5  = (a[15] ? hmpr_m[4:0] : lmpr_m[4:0]) + {4'd0, a[14]};
		if (rom)
			page = coupe_pkg::ROM_PAGE_BASE + {8'd0, a[15]};
		else if (ext)
			page = coupe_pkg::EXT_PAGE_BASE + {1'b0, (a[14] ? ext_d_m : ext_c_m)};
		else
			page = {4'd0, pg5};
		wok = !(rom || (lmpr_m[7] && sect == 2'd0) || (ext && !ext_ena_m));
		return {rom, wok, page, a[13:0]};
	endfunction

	// Voice byte at 10 and at 2, beeper at 16
	function automatic logic [17:0] mix_ref(input logic [7:0] v, input logic ear);
		logic [17:0] s;
		s = ({10'd0, v} << 10) + ({10'd0, v} << 2);
		if (ear)
			s = s + 18'h10000;
		return s;
	endfunction

	task automatic measure_window(output int tx_n, output int int_n, output logic last_int);
		tx_n     = 0;
		int_n    = 0;
		last_int = 1'b0;
		while (!midi_tx)
			@(negedge clk_sys);
		while (midi_tx) begin
			tx_n++;
			if (midi_int)
				int_n++;
			last_int = midi_int;
			if (addr[7:0] == coupe_pkg::PORT_STATUS)
				check("status", {4'hF, !(tx_n > FRAME - INT_CY), 3'h7}, asic_dout);
			@(negedge clk_sys);
		end
	endtask

	initial begin
		logic [7:0]         port;
		logic [15:0]        a;
		logic [24:0]        exp_map;
		int                 tx_n;
		int                 int_n;
		int                 falls;
		int                 n;
		logic               last_int;
		logic               prev_tx;
		coupe_pkg::sample_t prev;

		reset       = 1'b1;
		addr        = '0;
		din         = '0;
		io_wr       = 1'b0;
		ext_ram_off = 1'b0;
		sid_sample  = '0;
		sid_active  = 1'b0;
		apply_reset(1'b0);

		// ====================
		// Register tests
		// ====================
		start_test("register readback");
		for (int i = 0; i < 200; i++) begin
			port = ($random(seed) & 1) ? coupe_pkg::PORT_HMPR : coupe_pkg::PORT_LMPR;
			write_port(port, 8'($random(seed)));
			set_addr({8'h00, port});
			check("readback", (port == coupe_pkg::PORT_LMPR) ? lmpr_m : hmpr_m, asic_dout);
			port = 8'($random(seed));
			if (port < 8'd249 || port > 8'd251) begin
				set_addr({8'($random(seed)), port});
				check("unused port", 8'hFF, asic_dout);
			end
		end
		end_test();

		start_test("memory map");
		for (int cfg = 0; cfg < 10; cfg++) begin
			apply_reset(cfg[0]);
			write_port(coupe_pkg::PORT_LMPR, 8'($random(seed)));
			write_port(coupe_pkg::PORT_HMPR, 8'($random(seed)));
			write_port(coupe_pkg::PORT_EXT_C, 8'($random(seed)));
			write_port(coupe_pkg::PORT_EXT_D, 8'($random(seed)));
			for (int i = 0; i < 30; i++) begin
				a = 16'($random(seed));
				set_addr(a);
				exp_map = map_ref(a);
				check("mem_addr", exp_map[22:0], mem_addr);
				check("mem_rom", exp_map[24], mem_rom);
				check("mem_write_ok", exp_map[23], mem_write_ok);
			end
		end
		end_test();

		start_test("border");
		apply_reset(1'b0);
		for (int i = 0; i < 50; i++) begin
			write_port(coupe_pkg::PORT_BORDER, 8'($random(seed)));
			@(negedge clk_sys);
			check("border_color", {border_m[5], border_m[2:0]}, border_color);
			check("beeper", {border_m[4], 16'h0000}, audio_l);
		end
		end_test();

		start_test("voice mix");
		write_port(coupe_pkg::PORT_LPT_DATA, 8'($random(seed)));
		for (int i = 0; i < 100; i++) begin
			port = ($random(seed) & 1) ? coupe_pkg::PORT_LPT_STB : coupe_pkg::PORT_LPT_DATA;
			write_port(port, 8'($random(seed)));
			@(negedge clk_sys);
			check("audio_l", mix_ref(vox_l_m, border_m[4]), audio_l);
			check("audio_r", mix_ref(vox_r_m, border_m[4]), audio_r);
		end
		end_test();

		// ====================
		// MIDI and SID
		// ====================
		start_test("MIDI timing");
		fork
			begin
				write_port(coupe_pkg::PORT_MIDI, 8'($random(seed)));
				set_addr({8'h00, coupe_pkg::PORT_STATUS});
			end
			measure_window(tx_n, int_n, last_int);
		join
		check("tx cycles", FRAME, tx_n);
		check("int cycles", INT_CY, int_n);
		check("int at window end", 1, last_int);
		check("int falls with tx", 0, midi_int);
		fork
			write_port(coupe_pkg::PORT_MIDI, 8'($random(seed)));
			while (!midi_tx)
				@(negedge clk_sys);
		join
		write_port(coupe_pkg::PORT_MIDI, 8'($random(seed))); // Both land in the window
		write_port(coupe_pkg::PORT_MIDI, 8'($random(seed)));
		set_addr({8'h00, coupe_pkg::PORT_STATUS});
		falls   = 0;
		prev_tx = midi_tx;
		repeat (FRAME * 7 / 2) begin
			@(negedge clk_sys);
			if (prev_tx && !midi_tx)
				falls++;
			prev_tx = midi_tx;
		end
		check("windows ended", 2, falls);
		end_test();

		start_test("SID soft mute");
		apply_reset(1'b0);
		@(posedge clk_sys);
		sid_sample <= 18'h3FFFF - 18'($random(seed) & 31);
		sid_active <= 1'b1;
		prev = '0;
		repeat (64 * CE_DIV) begin
			@(negedge clk_sys);
			check("output never falls", 1, audio_l >= prev);
			check("output within sample", 1, audio_l <= sid_sample);
			prev = audio_l;
		end
		check("mute opened", 1, prev != '0);
		@(posedge clk_sys);
		sid_active <= 1'b0;
		@(negedge clk_sys);
		n = 0;
		while (audio_l != '0 && n < 80 * CE_DIV) begin
			@(negedge clk_sys);
			n++;
		end
		check("mute release", 0, audio_l);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== coupe_asic.sv ====
// SAM Coupe ASIC top level
`default_nettype none

module coupe_asic #(
	parameter int CE_DIV = 96 // Clocks per 1 us tick
) (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire coupe_pkg::cpu_addr_t addr,
	input  wire coupe_pkg::byte_t     din,
	input  wire                    io_wr,
	input  wire                    ext_ram_off,
	input  wire coupe_pkg::sample_t   sid_sample,
	input  wire                    sid_active,
	output coupe_pkg::byte_t       asic_dout,
	output coupe_pkg::mem_addr_t   mem_addr,
	output logic                   mem_rom,
	output logic                   mem_write_ok,
	output logic [3:0]             border_color,
	output logic                   midi_tx,
	output logic                   midi_int,
	output coupe_pkg::sample_t     audio_l,
	output coupe_pkg::sample_t     audio_r
);

	io_bus_if bus ();
	paging_if paging ();

	logic             ear_out;
	coupe_pkg::byte_t vox_l;
	coupe_pkg::byte_t vox_r;

	// ====================
	// Ports and memory
	// ====================
	port_regs regs_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.addr         (addr),
		.din          (din),
		.io_wr        (io_wr),
		.ext_ram_off  (ext_ram_off),
		.midi_int     (midi_int),
		.bus          (bus.send),
		.paging       (paging.send),
		.asic_dout    (asic_dout),
		.border_color (border_color),
		.ear_out      (ear_out)
	);

	mem_mapper mapper_i (
		.addr         (addr),
		.paging       (paging.receive),
		.mem_addr     (mem_addr),
		.mem_rom      (mem_rom),
		.mem_write_ok (mem_write_ok)
	);

	// ====================
	// MIDI and sound
	// ====================
	midi_serial #(
		.CE_DIV (CE_DIV)
	) midi_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.bus      (bus.timer),
		.midi_tx  (midi_tx),
		.midi_int (midi_int)
	);

	vox_dac vox_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus.receive),
		.vox_l   (vox_l),
		.vox_r   (vox_r)
	);

	audio_mixer mixer_i (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.bus        (bus.receive),
		.vox_l      (vox_l),
		.vox_r      (vox_r),
		.ear_out    (ear_out),
		.sid_sample (sid_sample),
		.sid_active (sid_active),
		.audio_l    (audio_l),
		.audio_r    (audio_r)
	);

endmodule

`default_nettype wire

// ==== audio_mixer.sv ====
// Audio mixer with SID soft mute
`default_nettype none

module audio_mixer (
	input  wire                 clk_sys,
	input  wire                 reset,
	io_bus_if.receive           bus,
	input  wire coupe_pkg::byte_t   vox_l,
	input  wire coupe_pkg::byte_t   vox_r,
	input  wire                 ear_out,
	input  wire coupe_pkg::sample_t sid_sample,
	input  wire                 sid_active,
	output coupe_pkg::sample_t  audio_l,
	output coupe_pkg::sample_t  audio_r
);

	coupe_pkg::sample_t att;
	coupe_pkg::sample_t sid_muted;

	// One channel sum that wraps at 18 bits
	function automatic coupe_pkg::sample_t mix(
		input coupe_pkg::byte_t   vox,
		input logic               ear,
		input coupe_pkg::sample_t sid
	);
		return {vox, vox, 2'b00} + {1'b0, ear, 16'd0} + sid;
	endfunction

	// ====================
	// Soft mute
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			att <= '1; // Fully muted
		end else if (bus.tick) begin
			if (sid_active && att != '0)
				att <= att - 1'b1;
			else if (!sid_active && att != '1)
				att <= att + 1'b1;
		end
	end

	assign sid_muted = (sid_sample > att) ? sid_sample - att : '0;

	assign audio_l = mix(vox_l, ear_out, sid_muted);
	assign audio_r = mix(vox_r, ear_out, sid_muted);

endmodule

`default_nettype wire

// ==== vox_dac.sv ====
// Parallel port voice sample latch
`default_nettype none

module vox_dac (
	input  wire              clk_sys,
	input  wire              reset,
	io_bus_if.receive        bus,
	output coupe_pkg::byte_t vox_l,
	output coupe_pkg::byte_t vox_r
);

	coupe_pkg::byte_t lpt_data;
	logic             old_stb;
	logic             stb_wr;

	assign stb_wr = bus.wr_stb && (bus.port == coupe_pkg::PORT_LPT_STB);

	always_ff @(posedge clk_sys) begin
		if (bus.wr_stb && bus.port == coupe_pkg::PORT_LPT_DATA)
			lpt_data <= bus.data;
	end

	// Strobe edge picks the channel
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_stb <= 1'b0;
			vox_l   <= '0;
			vox_r   <= '0;
		end else if (stb_wr) begin
			if (!old_stb && bus.data[0])
				vox_l <= lpt_data; // Rising strobe
			if (old_stb && !bus.data[0])
				vox_r <= lpt_data; // Falling strobe
			old_stb <= bus.data[0];
		end
	end

endmodule

`default_nettype wire

// ==== midi_serial.sv ====
// MIDI transmit timing
`default_nettype none

module midi_serial #(
	parameter int CE_DIV = 96
) (
	input  wire      clk_sys,
	input  wire      reset,
	io_bus_if.timer  bus,
	output logic     midi_tx,
	output logic     midi_int
);

	localparam int DIV_W = (CE_DIV > 1) ? $clog2(CE_DIV) : 1;
	localparam int CNT_W = $clog2(coupe_pkg::MIDI_FRAME_TICKS);

	logic [DIV_W-1:0] div_cnt;
	logic [CNT_W-1:0] tx_time; // Window ticks left
	logic             pending;
	logic             tick;

	// ====================
	// 1 us timebase
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset)
			div_cnt <= '0;
		else if (div_cnt == DIV_W'(CE_DIV - 1))
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	assign tick     = (div_cnt == '0);
	assign bus.tick = tick;

	// ====================
	// Transmit window
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			midi_tx  <= 1'b0;
			midi_int <= 1'b0;
			tx_time  <= '0;
			pending  <= 1'b0;
		end else begin
			if (tick) begin
				if (midi_tx) begin
					if (tx_time == '0) begin
						midi_tx  <= 1'b0;
						midi_int <= 1'b0;
					end else begin
						tx_time <= tx_time - 1'b1;
						if (tx_time == CNT_W'(coupe_pkg::MIDI_INT_TICKS))
							midi_int <= 1'b1; // Last ticks of the frame
					end
				end else if (pending) begin
					midi_tx <= 1'b1;
					tx_time <= CNT_W'(coupe_pkg::MIDI_FRAME_TICKS - 1);
					pending <= 1'b0;
				end
			end

			// A write during a window queues one more
			if (bus.wr_stb && bus.port == coupe_pkg::PORT_MIDI)
				pending <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== mem_mapper.sv ====
// CPU to physical memory mapper
`default_nettype none

module mem_mapper (
	input  wire coupe_pkg::cpu_addr_t addr,
	paging_if.receive            paging,
	output coupe_pkg::mem_addr_t mem_addr,
	output logic                 mem_rom,
	output logic                 mem_write_ok
);

	logic [1:0]         sect;
	logic               rom0_sel;
	logic               rom1_sel;
	logic               ram_wp;
	logic               ext_ram;
	logic [4:0]         ram_base;
	logic [4:0]         ram_page;
	coupe_pkg::page_t   page;

	assign sect = addr[15:14];

	assign rom0_sel = ~paging.lmpr[5] & (sect == 2'd0);
	assign rom1_sel =  paging.lmpr[6] & (sect == 2'd3);
	assign ram_wp   =  paging.lmpr[7] & (sect == 2'd0);
	assign ext_ram  =  paging.hmpr[7] & addr[15];

	assign mem_rom = rom0_sel | rom1_sel;

	// Odd section takes the next page and wraps in 32 pages
	assign ram_base = addr[15] ? paging.hmpr[4:0] : paging.lmpr[4:0];
	assign ram_page = ram_base + {4'd0, addr[14]};

	always_comb begin
		if (mem_rom) begin
			page = coupe_pkg::ROM_PAGE_BASE + coupe_pkg::page_t'(addr[15]);
		end else if (ext_ram) begin
			page = coupe_pkg::EXT_PAGE_BASE
				+ coupe_pkg::page_t'(addr[14] ? paging.ext_d : paging.ext_c);
		end else begin
			page = coupe_pkg::page_t'(ram_page);
		end
	end

	assign mem_addr = {page, addr[13:0]};

	// No writes to ROM, protected section 0 or absent external RAM
	assign mem_write_ok = ~(mem_rom | ram_wp | (ext_ram & ~paging.ext_ena));

endmodule

`default_nettype wire

// ==== port_regs.sv ====
// ASIC port registers
`default_nettype none

module port_regs (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire coupe_pkg::cpu_addr_t addr,
	input  wire coupe_pkg::byte_t     din,
	input  wire                  io_wr,
	input  wire                  ext_ram_off,
	input  wire                  midi_int,
	io_bus_if.send               bus,
	paging_if.send               paging,
	output coupe_pkg::byte_t     asic_dout,
	output logic [3:0]           border_color,
	output logic                 ear_out
);

	logic             io_wr_d;
	logic             stb_q;
	coupe_pkg::byte_t port_q;
	coupe_pkg::byte_t data_q;
	coupe_pkg::byte_t lmpr;
	coupe_pkg::byte_t hmpr;
	coupe_pkg::byte_t border;
	coupe_pkg::byte_t ext_c;
	coupe_pkg::byte_t ext_d;
	logic             ext_ena;

	// ====================
	// Write edge detect
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
			stb_q   <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
			stb_q   <= io_wr & ~io_wr_d; // First cycle of the write
		end
	end

	// Port and data as seen in the first write cycle
	always_ff @(posedge clk_sys) begin
		if (io_wr & ~io_wr_d) begin
			port_q <= addr[7:0];
			data_q <= din;
		end
	end

	assign bus.port   = port_q;
	assign bus.data   = data_q;
	assign bus.wr_stb = stb_q;

	// ====================
	// Registers
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr    <= '0;
			hmpr    <= '0;
			border  <= '0;
			ext_c   <= '0;
			ext_d   <= '0;
			ext_ena <= ~ext_ram_off; // Jumper sampled while in reset
		end else if (stb_q) begin
			case (port_q)
				coupe_pkg::PORT_LMPR:   lmpr   <= data_q;
				coupe_pkg::PORT_HMPR:   hmpr   <= data_q;
				coupe_pkg::PORT_BORDER: border <= data_q;
				coupe_pkg::PORT_EXT_C:  ext_c  <= data_q;
				coupe_pkg::PORT_EXT_D:  ext_d  <= data_q;
				default: ;
			endcase
		end
	end

	assign paging.lmpr    = lmpr;
	assign paging.hmpr    = hmpr;
	assign paging.ext_c   = ext_c;
	assign paging.ext_d   = ext_d;
	assign paging.ext_ena = ext_ena;

	assign border_color = {border[5], border[2:0]};
	assign ear_out      = border[4]; // Beeper

	// Readback with status bit 3 as the active-low MIDI interrupt
	always_comb begin
		case (addr[7:0])
			coupe_pkg::PORT_STATUS: asic_dout = {4'b1111, ~midi_int, 3'b111};
			coupe_pkg::PORT_LMPR:   asic_dout = lmpr;
			coupe_pkg::PORT_HMPR:   asic_dout = hmpr;
			default:                asic_dout = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

// ==== paging_if.sv ====
// Paging state to the memory mapper
`default_nettype none

interface paging_if;

	coupe_pkg::byte_t lmpr;    // Low memory page register
	coupe_pkg::byte_t hmpr;    // High memory page register
	coupe_pkg::byte_t ext_c;   // External RAM page for 8000h
	coupe_pkg::byte_t ext_d;   // External RAM page for C000h
	logic             ext_ena;

	modport send (
		output lmpr,
		output hmpr,
		output ext_c,
		output ext_d,
		output ext_ena
	);

	modport receive (
		input lmpr,
		input hmpr,
		input ext_c,
		input ext_d,
		input ext_ena
	);

endinterface

`default_nettype wire

// ==== io_bus_if.sv ====
// Decoded port write bus
`default_nettype none

interface io_bus_if;

	coupe_pkg::byte_t port; // Low byte of the I/O address
	coupe_pkg::byte_t data;
	logic             wr_stb; // One cycle per port write
	logic             tick;   // 1 us timebase

	// Register block publishes the write
	modport send (output port, output data, output wr_stb);

	// MIDI block watches its port and owns the timebase
	modport timer (input port, input wr_stb, output tick);

	// Sound blocks
	modport receive (input port, input data, input wr_stb, input tick);

endinterface

`default_nettype wire

// ==== coupe_pkg.sv ====
// SAM Coupe ASIC definitions
`default_nettype none

package coupe_pkg;

	// ====================
	// Types
	// ====================
	typedef logic [7:0]  byte_t;     // Data byte or port number
	typedef logic [15:0] cpu_addr_t;
	typedef logic [8:0]  page_t;     // 16 KB physical page
	typedef logic [22:0] mem_addr_t; // Page over 14-bit offset
	typedef logic [17:0] sample_t;   // Unsigned audio sample

	// ====================
	// I/O port numbers
	// ====================
	localparam byte_t PORT_EXT_C    = 8'd128;
	localparam byte_t PORT_EXT_D    = 8'd129;
	localparam byte_t PORT_LPT_DATA = 8'd232;
	localparam byte_t PORT_LPT_STB  = 8'd233;
	localparam byte_t PORT_STATUS   = 8'd249;
	localparam byte_t PORT_LMPR     = 8'd250;
	localparam byte_t PORT_HMPR     = 8'd251;
	localparam byte_t PORT_MIDI     = 8'd253;
	localparam byte_t PORT_BORDER   = 8'd254;

	// ====================
	// Memory map
	// ====================
	localparam page_t EXT_PAGE_BASE = 9'd64;  // First page of external RAM
	localparam page_t ROM_PAGE_BASE = 9'd256; // ROM 0 with ROM 1 next

	// MIDI transmit window in 1 us ticks
	localparam int MIDI_FRAME_TICKS = 320;
	localparam int MIDI_INT_TICKS   = 16;

endpackage

`default_nettype wire
